// File: project.f
source/isaPkg.sv
source/pipePkg.sv
source/pipeControl.sv
source/regFile.sv
source/operandSelect.sv
source/stageReg.sv
source/aluUnit.sv
source/resultSelect.sv
source/execCore.sv
tb/execChecker.sv
tb/tbExecCore.sv

// File: run.sh
#!/bin/sh
# Compile with Verilator and run the execute/writeback testbench.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module tbExecCore -f project.f -o simExecCore
./obj_dir/simExecCore > sim.log 2>&1
cat sim.log

if grep -qx "TEST OK" sim.log; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed"
exit 1

// File: tb/tbExecCore.sv
`timescale 1ns/100ps
`default_nettype none

module tbExecCore
	import isaPkg::*;
();

	localparam int numInstr     = 300;
	localparam int holdReadyFor = 100;
	localparam int watchdogNs   = numInstr * 10 * 20;

	logic        clk;
	logic        rstN;
	logic        inValid;
	logic        inReady;
	opT          inOp;
	regIdxT      inRs;
	regIdxT      inRt;
	regIdxT      inRd;
	logic [15:0] inImm;
	logic [4:0]  inShamt;
	wordT        inPc;
	logic        outValid;
	logic        outReady;
	regIdxT      outDest;
	wordT        outData;
	logic        endCheck;
	logic        randomReady;
	logic [31:0] inCount;
	logic [31:0] outCount;
	logic [31:0] mismatchCount;
	logic [31:0] otherCount;

	integer      seed;
	integer      readySeed;
	logic [31:0] readyDraw;
	regIdxT      recent [4];
	logic [1:0]  recentPtr;
	wordT        pc;

	execCore UUT (
		.clk(clk), .rstN(rstN),
		.inValid(inValid), .inReady(inReady), .inOp(inOp),
		.inRs(inRs), .inRt(inRt), .inRd(inRd),
		.inImm(inImm), .inShamt(inShamt), .inPc(inPc),
		.outValid(outValid), .outReady(outReady),
		.outDest(outDest), .outData(outData)
	);

	execChecker #(.instrCount(numInstr)) uChecker (
		.clk(clk), .rstN(rstN),
		.inValid(inValid), .inReady(inReady), .inOp(inOp),
		.inRs(inRs), .inRt(inRt), .inRd(inRd),
		.inImm(inImm), .inShamt(inShamt), .inPc(inPc),
		.outValid(outValid), .outReady(outReady),
		.outDest(outDest), .outData(outData),
		.endCheck(endCheck),
		.inCount(inCount), .outCount(outCount),
		.mismatchCount(mismatchCount), .otherCount(otherCount)
	);

	always #10 clk = ~clk;

	// ============================================================
	// Stimulus.
	// ============================================================

	// Half of the sources come from recent destinations to hit the forwards.
	function automatic regIdxT pickSource();
		logic [31:0] draw;
		draw = $random(seed);
		if (draw[0]) begin
			return recent[draw[2:1]];
		end
		return draw[12:8];
	endfunction

	function automatic regIdxT destOf(opT op, regIdxT rt, regIdxT rd);
		if (op == opJal) begin
			return 5'd31;
		end
		if (op == opAddiu || op == opOri || op == opLui) begin
			return rt;
		end
		return rd;
	endfunction

	task automatic driveInstr(input wordT instrPc);
		logic [31:0] draw;
		logic [31:0] extra;
		opT          op;
		regIdxT      rs;
		regIdxT      rt;
		regIdxT      rd;
		draw  = $random(seed);
		extra = $random(seed);
		op    = opT'(4'(draw[7:0] % 8'd12));
		rs    = pickSource();
		rt    = pickSource();
		rd    = draw[12:8];
		if (draw[15:13] == 3'd0) begin
			rd = 5'd0;
		end
		inValid <= 1'b1;
		inOp    <= op;
		inRs    <= rs;
		inRt    <= rt;
		inRd    <= rd;
		inImm   <= draw[31:16];
		inShamt <= extra[4:0];
		inPc    <= instrPc;
		recent[recentPtr] = destOf(op, rt, rd);
		recentPtr = recentPtr + 2'd1;
	endtask

	always @(posedge clk) begin
		if (randomReady) begin
			readyDraw = $random(readySeed);
			outReady <= readyDraw[0];
		end else begin
			outReady <= 1'b1;
		end
	end

	initial begin
		seed        = 57140;
		readySeed   = seed + 1;
		clk         = 1'b0;
		rstN        = 1'b0;
		inValid     = 1'b0;
		inOp        = opAddu;
		inRs        = '0;
		inRt        = '0;
		inRd        = '0;
		inImm       = '0;
		inShamt     = '0;
		inPc        = '0;
		outReady    = 1'b1;
		endCheck    = 1'b0;
		randomReady = 1'b0;
		recentPtr   = '0;
		pc          = 32'h0040_0000;
		for (int i = 0; i < 4; i++) begin
			recent[i] = regIdxT'(i + 1);
		end

		repeat (2) @(posedge clk);
		rstN <= 1'b1;
		@(posedge clk);

		for (int i = 0; i < numInstr; i++) begin
			logic [31:0] gapDraw;
			gapDraw = $random(seed);
			if (i == holdReadyFor) begin
				randomReady <= 1'b1;
			end
			if (gapDraw[2:0] == 3'd0) begin
				inValid <= 1'b0;
				repeat (1 + gapDraw[3]) @(posedge clk);
			end
			driveInstr(pc);
			pc = pc + 32'd4;
			// Ready is stable between edges, so look at it mid-cycle.
			@(negedge clk);
			while (!inReady) begin
				@(negedge clk);
			end
			@(posedge clk);
		end
		inValid     <= 1'b0;
		randomReady <= 1'b0;

		// Drain, then let the checker look at what is left.
		while (outCount < numInstr) begin
			@(posedge clk);
		end
		repeat (3) @(posedge clk);
		endCheck <= 1'b1;
		@(posedge clk);
		endCheck <= 1'b0;
		repeat (2) @(posedge clk);

		$display("results %0d of %0d accepted, mismatches %0d, other errors %0d",
			outCount, inCount, mismatchCount, otherCount);
		if (mismatchCount == 0 && otherCount == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	initial begin
		#(watchdogNs);
		$display("timeout: the run did not finish within %0d ns", watchdogNs);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/execChecker.sv
`timescale 1ns/100ps
`default_nettype none

module execChecker
	import isaPkg::*;
#(
	parameter int instrCount = 300
) (
	input  wire logic        clk,
	input  wire logic        rstN,
	input  wire logic        inValid,
	input  wire logic        inReady,
	input  wire opT          inOp,
	input  wire regIdxT      inRs,
	input  wire regIdxT      inRt,
	input  wire regIdxT      inRd,
	input  wire logic [15:0] inImm,
	input  wire logic [4:0]  inShamt,
	input  wire wordT        inPc,
	input  wire logic        outValid,
	input  wire logic        outReady,
	input  wire regIdxT      outDest,
	input  wire wordT        outData,
	input  wire logic        endCheck,
	output logic [31:0]      inCount,
	output logic [31:0]      outCount,
	output logic [31:0]      mismatchCount,
	output logic [31:0]      otherCount
);

	typedef struct packed {
		opT          op;
		regIdxT      rs;
		regIdxT      rt;
		regIdxT      rd;
		logic [15:0] imm;
		logic [4:0]  shamt;
		wordT        pc;
		logic [31:0] cycle;
	} pendingT;

	pendingT     pending [$];
	wordT        shadow [32];
	logic [31:0] cycle;
	logic [31:0] lastLowCycle;
	logic        resetChecked;
	logic [31:0] inCnt;
	logic [31:0] outCnt;
	logic [31:0] mismatchCnt;
	logic [31:0] otherCnt;

	// ============================================================
	// Reference model of the instruction set.
	// ============================================================

	// Returns the destination index in the top five bits and the value below.
	function automatic logic [36:0] expectedResult(opT op, wordT rsVal, wordT rtVal,
			regIdxT rt, regIdxT rd, logic [15:0] imm, logic [4:0] shamt, wordT pc);
		regIdxT dest;
		wordT   value;
		dest  = rd;
		value = '0;
		case (op)
			opAddu: value = rsVal + rtVal;
			opSubu: value = rsVal - rtVal;
			opAnd:  value = rsVal & rtVal;
			opOr:   value = rsVal | rtVal;
			opXor:  value = rsVal ^ rtVal;
			opSlt:  value = ($signed(rsVal) < $signed(rtVal)) ? 32'd1 : 32'd0;
			opSll:  value = rtVal << shamt;
			opSrl:  value = rtVal >> shamt;
			opAddiu: begin
				dest  = rt;
				value = rsVal + {{16{imm[15]}}, imm};
			end
			opOri: begin
				dest  = rt;
				value = rsVal | {16'h0000, imm};
			end
			opLui: begin
				dest  = rt;
				value = {imm, 16'h0000};
			end
			opJal: begin
				dest  = 5'd31;
				value = pc + 32'd8;
			end
			default: value = '0;
		endcase
		return {dest, value};
	endfunction

	// ============================================================
	// Comparison.
	// ============================================================

	task automatic clearState();
		for (int i = 0; i < 32; i++) begin
			shadow[i] = '0;
		end
		pending.delete();
		cycle        = '0;
		lastLowCycle = '0;
		resetChecked = 1'b0;
		inCnt        = '0;
		outCnt       = '0;
		mismatchCnt  = '0;
		otherCnt     = '0;
	endtask

	task automatic checkAfterReset();
		resetChecked = 1'b1;
		if (outValid !== 1'b0 || inReady !== 1'b1) begin
			mismatchCnt = mismatchCnt + 1;
			$display("mismatch reset state: expected outValid 0 inReady 1, actual outValid %b inReady %b",
				outValid, inReady);
		end
	endtask

	task automatic recordInput();
		pendingT entry;
		entry.op    = inOp;
		entry.rs    = inRs;
		entry.rt    = inRt;
		entry.rd    = inRd;
		entry.imm   = inImm;
		entry.shamt = inShamt;
		entry.pc    = inPc;
		entry.cycle = cycle;
		pending.push_back(entry);
		inCnt = inCnt + 1;
	endtask

	task automatic checkOutput();
		pendingT     entry;
		opT          op;
		logic [36:0] expected;
		logic [31:0] latency;
		outCnt = outCnt + 1;
		if (pending.size() == 0) begin
			otherCnt = otherCnt + 1;
			$display("output transfer at cycle %0d has no matching input transfer", cycle);
		end else begin
			entry    = pending.pop_front();
			op       = entry.op;
			expected = expectedResult(entry.op, shadow[entry.rs], shadow[entry.rt], entry.rt,
				entry.rd, entry.imm, entry.shamt, entry.pc);
			if (outDest !== expected[36:32] || outData !== expected[31:0]) begin
				mismatchCnt = mismatchCnt + 1;
				$display("mismatch result %0d (%s): expected r%0d = %h, actual r%0d = %h",
					outCnt, op.name(), expected[36:32], expected[31:0], outDest, outData);
			end
			if (expected[36:32] != 5'd0) begin
				shadow[expected[36:32]] = expected[31:0];
			end
			// With the sink ready since the input edge, the result takes two edges.
			latency = cycle - entry.cycle;
			if (lastLowCycle <= entry.cycle && latency != 32'd2) begin
				mismatchCnt = mismatchCnt + 1;
				$display("mismatch latency of result %0d: expected 2 cycles, actual %0d",
					outCnt, latency);
			end
		end
	endtask

	task automatic checkDrained();
		if (pending.size() != 0) begin
			otherCnt = otherCnt + 1;
			$display("%0d accepted instructions never produced a result", pending.size());
		end
		if (inCnt != instrCount) begin
			otherCnt = otherCnt + 1;
			$display("only %0d of %0d instructions were accepted", inCnt, instrCount);
		end
	endtask

	always @(posedge clk) begin
		if (!rstN) begin
			clearState();
		end else begin
			cycle = cycle + 1;
			if (!resetChecked) begin
				checkAfterReset();
			end
			if (!outReady) begin
				lastLowCycle = cycle;
			end
			if (outValid && outReady) begin
				checkOutput();
			end
			if (inValid && inReady) begin
				recordInput();
			end
			if (endCheck) begin
				checkDrained();
			end
		end
		inCount       <= inCnt;
		outCount      <= outCnt;
		mismatchCount <= mismatchCnt;
		otherCount    <= otherCnt;
	end

endmodule

`default_nettype wire

// File: source/execCore.sv
`timescale 1ns/100ps
`default_nettype none

module execCore
	import isaPkg::*;
	import pipePkg::*;
(
	input  wire logic       clk,
	input  wire logic       rstN,
	input  wire logic       inValid,
	output logic            inReady,
	input  wire opT         inOp,
	input  wire regIdxT     inRs,
	input  wire regIdxT     inRt,
	input  wire regIdxT     inRd,
	input  wire logic [15:0] inImm,
	input  wire logic [4:0] inShamt,
	input  wire wordT       inPc,
	output logic            outValid,
	input  wire logic       outReady,
	output regIdxT          outDest,
	output wordT            outData
);

	logic      exValid;
	logic      wbValid;
	logic      exAdvance;
	logic      wbAdvance;
	fwdSrcT    fwdA;
	fwdSrcT    fwdB;
	logic      selImmB;
	logic      selShamtA;
	regIdxT    destSel;
	wordT      fileA;
	wordT      fileB;
	wordT      extImm;
	wordT      opA;
	wordT      opB;
	wordT      aluResult;
	wordT      exValue;
	exPayloadT exIn;
	exPayloadT exOut;
	wbPayloadT wbIn;
	wbPayloadT wbOut;

	// ============================================================
	// Input side: control, register read, operand build.
	// ============================================================

	pipeControl uControl (
		.inOp(inOp), .inRs(inRs), .inRt(inRt), .inRd(inRd),
		.exValid(exValid), .exDest(exOut.dest),
		.wbValid(wbValid), .wbDest(wbOut.dest),
		.outReady(outReady), .inReady(inReady),
		.exAdvance(exAdvance), .wbAdvance(wbAdvance),
		.fwdA(fwdA), .fwdB(fwdB), .selImmB(selImmB),
		.selShamtA(selShamtA), .destSel(destSel)
	);

	// Results are written back as they leave the core.
	regFile uRegFile (
		.clk(clk), .rstN(rstN),
		.rdAddrA(inRs), .rdAddrB(inRt),
		.wrEn(outValid && outReady), .wrAddr(wbOut.dest), .wrData(wbOut.value),
		.rdDataA(fileA), .rdDataB(fileB)
	);

	assign extImm = extendImm(inImm, immKind(inOp));

	// The execute-stage forward uses the final value, so a jal in flight
	// forwards its link address.
	operandSelect uOperands (
		.fileA(fileA), .fileB(fileB), .exResult(exValue), .wbData(wbOut.value),
		.fwdA(fwdA), .fwdB(fwdB), .selImmB(selImmB), .selShamtA(selShamtA),
		.extImm(extImm), .shamt(inShamt), .opA(opA), .opB(opB)
	);

	always_comb begin
		exIn.op   = inOp;
		exIn.dest = destSel;
		exIn.opA  = opA;
		exIn.opB  = opB;
		exIn.pc   = inPc;
	end

	// ============================================================
	// Execute stage.
	// ============================================================

	stageReg #(.PayloadT(exPayloadT)) uExStage (
		.clk(clk), .rstN(rstN), .advance(exAdvance),
		.inValid(inValid), .inData(exIn),
		.valid(exValid), .data(exOut)
	);

	aluUnit uAlu (
		.op(exOut.op), .opA(exOut.opA), .opB(exOut.opB), .result(aluResult)
	);

	resultSelect uResult (
		.op(exOut.op), .aluResult(aluResult), .pc(exOut.pc), .value(exValue)
	);

	always_comb begin
		wbIn.dest  = exOut.dest;
		wbIn.value = exValue;
	end

	// ============================================================
	// Writeback stage.
	// ============================================================

	stageReg #(.PayloadT(wbPayloadT)) uWbStage (
		.clk(clk), .rstN(rstN), .advance(wbAdvance),
		.inValid(exValid), .inData(wbIn),
		.valid(wbValid), .data(wbOut)
	);

	assign outValid = wbValid;
	assign outDest  = wbOut.dest;
	assign outData  = wbOut.value;

endmodule

`default_nettype wire

// File: source/resultSelect.sv
`timescale 1ns/100ps
`default_nettype none

module resultSelect
	import isaPkg::*;
	import pipePkg::*;
(
	input  wire opT   op,
	input  wire wordT aluResult,
	input  wire wordT pc,
	output wordT      value
);

	wordT linkAddr;

	// Return address skips the delay slot.
	assign linkAddr = pc + 32'd8;

	always_comb begin
		if (isLink(op)) begin
			value = linkAddr;
		end else begin
			value = aluResult;
		end
	end

endmodule

`default_nettype wire

// File: source/aluUnit.sv
`timescale 1ns/100ps
`default_nettype none

module aluUnit
	import isaPkg::*;
(
	input  wire opT   op,
	input  wire wordT opA,
	input  wire wordT opB,
	output wordT      result
);

	logic lessThan;

	assign lessThan = $signed(opA) < $signed(opB);

	// ============================================================
	// Operation decode.
	// ============================================================

	always_comb begin
		case (op)
			opAddu, opAddiu: begin
				result = opA + opB;
			end
			opSubu: begin
				result = opA - opB;
			end
			opAnd: begin
				result = opA & opB;
			end
			opOr, opOri: begin
				result = opA | opB;
			end
			opXor: begin
				result = opA ^ opB;
			end
			opSlt: begin
				result = {31'd0, lessThan};
			end
			// Shift amount sits in the low bits of the first operand.
			opSll: begin
				result = opB << opA[4:0];
			end
			opSrl: begin
				result = opB >> opA[4:0];
			end
			opLui: begin
				result = opB;
			end
			default: begin
				result = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: source/stageReg.sv
`timescale 1ns/100ps
`default_nettype none

module stageReg #(
	parameter type PayloadT = logic
) (
	input  wire logic    clk,
	input  wire logic    rstN,
	input  wire logic    advance,
	input  wire logic    inValid,
	input  wire PayloadT inData,
	output logic         valid,
	output PayloadT      data
);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			valid <= 1'b0;
		end else if (advance) begin
			valid <= inValid;
		end
	end

	// Payload is only meaningful while valid is set.
	always_ff @(posedge clk) begin
		if (advance && inValid) begin
			data <= inData;
		end
	end

endmodule

`default_nettype wire

// File: source/operandSelect.sv
`timescale 1ns/100ps
`default_nettype none

module operandSelect
	import isaPkg::*;
	import pipePkg::*;
(
	input  wire wordT       fileA,
	input  wire wordT       fileB,
	input  wire wordT       exResult,
	input  wire wordT       wbData,
	input  wire fwdSrcT     fwdA,
	input  wire fwdSrcT     fwdB,
	input  wire logic       selImmB,
	input  wire logic       selShamtA,
	input  wire wordT       extImm,
	input  wire logic [4:0] shamt,
	output wordT            opA,
	output wordT            opB
);

	wordT fwdValA;
	wordT fwdValB;

	function automatic wordT forward(fwdSrcT src, wordT fromRegs, wordT exVal,
			wordT wbVal);
		case (src)
			fromEx:  return exVal;
			fromWb:  return wbVal;
			default: return fromRegs;
		endcase
	endfunction

	// ============================================================
	// Forwarding selectors.
	// ============================================================

	assign fwdValA = forward(fwdA, fileA, exResult, wbData);
	assign fwdValB = forward(fwdB, fileB, exResult, wbData);

	// ============================================================
	// ALU source selectors.
	// ============================================================

	always_comb begin
		if (selShamtA) begin
			opA = {27'd0, shamt};
		end else begin
			opA = fwdValA;
		end
	end

	always_comb begin
		if (selImmB) begin
			opB = extImm;
		end else begin
			opB = fwdValB;
		end
	end

endmodule

`default_nettype wire

// File: source/regFile.sv
`timescale 1ns/100ps
`default_nettype none

module regFile
	import isaPkg::*;
(
	input  wire logic   clk,
	input  wire logic   rstN,
	input  wire regIdxT rdAddrA,
	input  wire regIdxT rdAddrB,
	input  wire logic   wrEn,
	input  wire regIdxT wrAddr,
	input  wire wordT   wrData,
	output wordT        rdDataA,
	output wordT        rdDataB
);

	// Register 0 has no storage.
	wordT regs [31:1];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn && (wrAddr != '0)) begin
			regs[wrAddr] <= wrData;
		end
	end

	// No write-through here. A same-cycle write is covered by the
	// writeback forward in the operand selector.
	assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
	assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

`default_nettype wire

// File: source/pipeControl.sv
`timescale 1ns/100ps
`default_nettype none

module pipeControl
	import isaPkg::*;
	import pipePkg::*;
(
	input  wire opT     inOp,
	input  wire regIdxT inRs,
	input  wire regIdxT inRt,
	input  wire regIdxT inRd,
	input  wire logic   exValid,
	input  wire regIdxT exDest,
	input  wire logic   wbValid,
	input  wire regIdxT wbDest,
	input  wire logic   outReady,
	output logic        inReady,
	output logic        exAdvance,
	output logic        wbAdvance,
	output fwdSrcT      fwdA,
	output fwdSrcT      fwdB,
	output logic        selImmB,
	output logic        selShamtA,
	output regIdxT      destSel
);

	// Picks the youngest in-flight producer of a source register.
	function automatic fwdSrcT pickSrc(regIdxT src, logic exV, regIdxT exD,
			logic wbV, regIdxT wbD);
		if (src == '0) begin
			return fromFile;
		end
		if (exV && (exD == src)) begin
			return fromEx;
		end
		if (wbV && (wbD == src)) begin
			return fromWb;
		end
		return fromFile;
	endfunction

	// ============================================================
	// Stall chain.
	// ============================================================

	// Writeback moves when empty or drained; execute moves when it is empty
	// or has somewhere to go.
	assign wbAdvance = !wbValid || outReady;
	assign exAdvance = !exValid || wbAdvance;
	assign inReady   = exAdvance;

	// ============================================================
	// Forwarding and decode.
	// ============================================================

	assign fwdA = pickSrc(inRs, exValid, exDest, wbValid, wbDest);
	assign fwdB = pickSrc(inRt, exValid, exDest, wbValid, wbDest);

	assign selImmB   = usesImm(inOp);
	assign selShamtA = (inOp == opSll) || (inOp == opSrl);

	always_comb begin
		if (isLink(inOp)) begin
			destSel = 5'd31;
		end else if (writesRd(inOp)) begin
			destSel = inRd;
		end else begin
			destSel = inRt;
		end
	end

endmodule

`default_nettype wire

// File: source/pipePkg.sv
`default_nettype none

package pipePkg;
	import isaPkg::*;

	// Where a source operand is taken from.
	typedef enum logic [1:0] {
		fromFile = 2'd0,
		fromEx   = 2'd1,
		fromWb   = 2'd2
	} fwdSrcT;

	// ============================================================
	// Stage payloads.
	// ============================================================

	// Operands are already forwarded and source-selected when captured.
	typedef struct packed {
		opT     op;
		regIdxT dest;
		wordT   opA;
		wordT   opB;
		wordT   pc;
	} exPayloadT;

	typedef struct packed {
		regIdxT dest;
		wordT   value;
	} wbPayloadT;

endpackage

`default_nettype wire

// File: source/isaPkg.sv
`default_nettype none

package isaPkg;

	typedef logic [4:0] regIdxT;
	typedef logic [31:0] wordT;

	typedef enum logic [3:0] {
		opAddu, opSubu, opAnd, opOr, opXor, opSlt, opSll, opSrl,
		opAddiu, opOri, opLui, opJal
	} opT;

	typedef enum logic [1:0] {
		immSign, immZero, immUpper
	} immKindT;

	// ============================================================
	// Operation classes.
	// ============================================================

	function automatic logic usesImm(opT op);
		return (op == opAddiu) || (op == opOri) || (op == opLui);
	endfunction

	function automatic logic writesRd(opT op);
		return !usesImm(op) && (op != opJal);
	endfunction

	function automatic logic isLink(opT op);
		return op == opJal;
	endfunction

	function automatic immKindT immKind(opT op);
		case (op)
			opAddiu: return immSign;
			opLui:   return immUpper;
			default: return immZero;
		endcase
	endfunction

	function automatic wordT extendImm(logic [15:0] imm, immKindT kind);
		case (kind)
			immSign:  return {{16{imm[15]}}, imm};
			immUpper: return {imm, 16'h0000};
			default:  return {16'h0000, imm};
		endcase
	endfunction

endpackage

`default_nettype wire
